// ==== sources.f ====
rs_pkg.sv
rs_entry.sv
rs_alloc.sv
rs_issue_select.sv
reservation_station.sv
tb_reservation_station.sv

// ==== Makefile ====
LOG = sim.log

sim:
	verilator --binary --timing --assert -f sources.f --top-module tb_reservation_station -o tb_reservation_station
	./obj_dir/tb_reservation_station | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== tb_reservation_station.sv ====
`timescale 1ns/1ps
// table-driven testbench for the reservation station, one row per clock cycle
// rows are driven 1 ns after the rising edge and checked 1 ns before the next one
// expected issue fields are dest_tag and both operand values
// an idle port expects all of them zero
module tb_reservation_station;

   import rs_pkg::*;

   typedef struct packed
   {
      logic   valid;
      tag_t   dest_tag;
      value_t rega_value;
      value_t regb_value;
   } expect_t;

   typedef struct packed
   {
      dispatch_t inst1;
      dispatch_t inst2;
      cdb_t      cdb1;
      cdb_t      cdb2;
      logic      ready;
      expect_t   issue1;
      expect_t   issue2;
   } row_t;

   localparam dispatch_t NO_INST  = '0;
   localparam cdb_t      IDLE_CDB = {TAG_NULL, 64'h0};
   localparam expect_t   NO_ISSUE = '0;

   logic      clock = 1'b0;
   logic      reset;
   dispatch_t inst1;
   dispatch_t inst2;
   cdb_t      cdb1;
   cdb_t      cdb2;
   logic      dispatch_ready;
   issue_t    issue1;
   issue_t    issue2;

   row_t      rows[$];
   logic      table_built = 1'b0;
   int        checks = 0;
   int        errors = 0;

   reservation_station #(.NUM_ENTRIES(8)) i_reservation_station
   (
      .clock          (clock),
      .reset          (reset),
      .inst1          (inst1),
      .inst2          (inst2),
      .cdb1           (cdb1),
      .cdb2           (cdb2),
      .dispatch_ready (dispatch_ready),
      .issue1         (issue1),
      .issue2         (issue2)
   );

   always #5 clock = ~clock;

   ////////////////////////////////////////////////////////////
   // row builders
   ////////////////////////////////////////////////////////////

   function automatic dispatch_t make_inst(tag_t dest, value_t a, value_t b,
                                           tag_t a_tag, tag_t b_tag);
      dispatch_t d;
      d               = '0;
      d.valid         = 1'b1;
      d.op.dest_tag   = dest;
      d.op.dest_reg   = dest[4:0];
      d.rega_value    = a;
      d.regb_value    = b;
      d.rega_tag      = a_tag;
      d.regb_tag      = b_tag;
      return d;
   endfunction

   function automatic cdb_t bcast(tag_t t, value_t v);
      cdb_t c;
      c.tag   = t;
      c.value = v;
      return c;
   endfunction

   function automatic expect_t issued(tag_t t, value_t a, value_t b);
      expect_t e;
      e.valid      = 1'b1;
      e.dest_tag   = t;
      e.rega_value = a;
      e.regb_value = b;
      return e;
   endfunction

   task automatic add_row(dispatch_t i1, dispatch_t i2, cdb_t c1, cdb_t c2, logic rdy,
                          expect_t e1, expect_t e2);
      row_t r;
      r.inst1  = i1;
      r.inst2  = i2;
      r.cdb1   = c1;
      r.cdb2   = c2;
      r.ready  = rdy;
      r.issue1 = e1;
      r.issue2 = e2;
      rows.push_back(r);
   endtask

   task automatic check_value(int row, string name, logic [63:0] actual,
                              logic [63:0] expected);
      checks++;
      assert (actual === expected)
      else
      begin
         errors++;
         $display("mismatch at %0t row %0d: %s expected %h actual %h",
                  $time, row, name, expected, actual);
      end
   endtask

   task automatic check_row(int row, row_t r);
      check_value(row, "dispatch_ready", 64'(dispatch_ready), 64'(r.ready));
      check_value(row, "issue1.valid", 64'(issue1.valid), 64'(r.issue1.valid));
      check_value(row, "issue1.dest_tag", 64'(issue1.op.dest_tag), 64'(r.issue1.dest_tag));
      check_value(row, "issue1.rega_value", issue1.rega_value, r.issue1.rega_value);
      check_value(row, "issue1.regb_value", issue1.regb_value, r.issue1.regb_value);
      check_value(row, "issue2.valid", 64'(issue2.valid), 64'(r.issue2.valid));
      check_value(row, "issue2.dest_tag", 64'(issue2.op.dest_tag), 64'(r.issue2.dest_tag));
      check_value(row, "issue2.rega_value", issue2.rega_value, r.issue2.rega_value);
      check_value(row, "issue2.regb_value", issue2.regb_value, r.issue2.regb_value);
   endtask

   ////////////////////////////////////////////////////////////
   // stimulus table
   ////////////////////////////////////////////////////////////

   task automatic build_table();
      // idle after reset
      add_row(NO_INST, NO_INST, IDLE_CDB, IDLE_CDB, 1'b1, NO_ISSUE, NO_ISSUE);
      // a ready pair issues together in the next cycle
      add_row(make_inst(8'h10, 64'h100, 64'h101, TAG_NULL, TAG_NULL),
              make_inst(8'h11, 64'h110, 64'h111, TAG_NULL, TAG_NULL),
              IDLE_CDB, IDLE_CDB, 1'b1, NO_ISSUE, NO_ISSUE);
      add_row(NO_INST, NO_INST, IDLE_CDB, IDLE_CDB, 1'b1,
              issued(8'h10, 64'h100, 64'h101), issued(8'h11, 64'h110, 64'h111));
      // wakeup on cdb1 one cycle after dispatch
      add_row(make_inst(8'h20, 64'hbad0, 64'h201, 8'h30, TAG_NULL), NO_INST,
              IDLE_CDB, IDLE_CDB, 1'b1, NO_ISSUE, NO_ISSUE);
      add_row(NO_INST, NO_INST, bcast(8'h30, 64'h300), IDLE_CDB, 1'b1, NO_ISSUE, NO_ISSUE);
      add_row(NO_INST, NO_INST, IDLE_CDB, IDLE_CDB, 1'b1,
              issued(8'h20, 64'h300, 64'h201), NO_ISSUE);
      // wakeup on cdb2 in the dispatch cycle itself
      add_row(make_inst(8'h21, 64'h210, 64'hbad1, TAG_NULL, 8'h31), NO_INST,
              IDLE_CDB, bcast(8'h31, 64'h310), 1'b1, NO_ISSUE, NO_ISSUE);
      add_row(NO_INST, NO_INST, IDLE_CDB, IDLE_CDB, 1'b1,
              issued(8'h21, 64'h210, 64'h310), NO_ISSUE);
      // entry 1 is freed early and refilled, so age order differs from index order
      add_row(make_inst(8'h22, 64'hbad2, 64'h221, 8'h40, TAG_NULL),
              make_inst(8'h23, 64'h230, 64'h231, TAG_NULL, TAG_NULL),
              IDLE_CDB, IDLE_CDB, 1'b1, NO_ISSUE, NO_ISSUE);
      add_row(make_inst(8'h24, 64'hbad4, 64'h241, 8'h40, TAG_NULL),
              make_inst(8'h25, 64'h250, 64'hbad5, TAG_NULL, 8'h41),
              IDLE_CDB, IDLE_CDB, 1'b1, issued(8'h23, 64'h230, 64'h231), NO_ISSUE);
      // four entries woken together, ages by index 4 0 2 1
      add_row(make_inst(8'h26, 64'hbad7, 64'h261, 8'h40, TAG_NULL), NO_INST,
              bcast(8'h40, 64'h400), bcast(8'h41, 64'h410), 1'b1, NO_ISSUE, NO_ISSUE);
      add_row(NO_INST, NO_INST, IDLE_CDB, IDLE_CDB, 1'b1,
              issued(8'h22, 64'h400, 64'h221), issued(8'h24, 64'h400, 64'h241));
      add_row(NO_INST, NO_INST, IDLE_CDB, IDLE_CDB, 1'b1,
              issued(8'h25, 64'h250, 64'h410), issued(8'h26, 64'h400, 64'h261));
      // fill seven entries waiting on tag 50
      for (int k = 0; k < 6; k += 2)
         add_row(make_inst(tag_t'(8'h60 + k), 64'hbad6, 64'h601 + 64'(k) * 64'h10, 8'h50,
                           TAG_NULL),
                 make_inst(tag_t'(8'h61 + k), 64'hbad6, 64'h611 + 64'(k) * 64'h10, 8'h50,
                           TAG_NULL),
                 IDLE_CDB, IDLE_CDB, 1'b1, NO_ISSUE, NO_ISSUE);
      add_row(make_inst(8'h66, 64'hbad6, 64'h661, 8'h50, TAG_NULL), NO_INST,
              IDLE_CDB, IDLE_CDB, 1'b1, NO_ISSUE, NO_ISSUE);
      // offers are dropped while only one entry is left
      add_row(make_inst(8'h70, 64'h700, 64'h701, TAG_NULL, TAG_NULL),
              make_inst(8'h71, 64'h710, 64'h711, TAG_NULL, TAG_NULL),
              IDLE_CDB, IDLE_CDB, 1'b0, NO_ISSUE, NO_ISSUE);
      add_row(make_inst(8'h70, 64'h700, 64'h701, TAG_NULL, TAG_NULL), NO_INST,
              bcast(8'h50, 64'h500), IDLE_CDB, 1'b0, NO_ISSUE, NO_ISSUE);
      add_row(NO_INST, NO_INST, IDLE_CDB, IDLE_CDB, 1'b0,
              issued(8'h60, 64'h500, 64'h601), issued(8'h61, 64'h500, 64'h611));
      add_row(NO_INST, NO_INST, IDLE_CDB, IDLE_CDB, 1'b1,
              issued(8'h62, 64'h500, 64'h621), issued(8'h63, 64'h500, 64'h631));
      add_row(NO_INST, NO_INST, IDLE_CDB, IDLE_CDB, 1'b1,
              issued(8'h64, 64'h500, 64'h641), issued(8'h65, 64'h500, 64'h651));
      add_row(NO_INST, NO_INST, IDLE_CDB, IDLE_CDB, 1'b1,
              issued(8'h66, 64'h500, 64'h661), NO_ISSUE);
      // the dropped offers never show up
      add_row(NO_INST, NO_INST, IDLE_CDB, IDLE_CDB, 1'b1, NO_ISSUE, NO_ISSUE);
      add_row(NO_INST, NO_INST, IDLE_CDB, IDLE_CDB, 1'b1, NO_ISSUE, NO_ISSUE);
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence and watchdog
   ////////////////////////////////////////////////////////////

   initial
   begin
      reset = 1'b1;
      inst1 = NO_INST;
      inst2 = NO_INST;
      cdb1  = IDLE_CDB;
      cdb2  = IDLE_CDB;
      build_table();
      table_built = 1'b1;
      repeat (3) @(posedge clock);
      #1;
      reset = 1'b0;
      for (int r = 0; r < rows.size(); r++)
      begin
         inst1 = rows[r].inst1;
         inst2 = rows[r].inst2;
         cdb1  = rows[r].cdb1;
         cdb2  = rows[r].cdb2;
         #8;
         check_row(r, rows[r]);
         @(posedge clock);
         #1;
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

   initial
   begin
      wait (table_built);
      #((rows.size() + 10) * 10);
      $display("timeout: the run did not finish within %0d cycles", rows.size() + 10);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

// ==== reservation_station.sv ====
`timescale 1ns/1ps
// two-wide reservation station
// decode must hold its instructions while dispatch_ready is low
// issue has no back-pressure, picked entries are freed at the next edge
module reservation_station
#(
   parameter int NUM_ENTRIES = 8
)
(
   input  logic              clock,
   input  logic              reset,
   input  rs_pkg::dispatch_t inst1,
   input  rs_pkg::dispatch_t inst2,
   input  rs_pkg::cdb_t      cdb1,
   input  rs_pkg::cdb_t      cdb2,
   output logic              dispatch_ready,
   output rs_pkg::issue_t    issue1,
   output rs_pkg::issue_t    issue2
);

   import rs_pkg::*;

   logic [NUM_ENTRIES-1:0] empty;
   logic [NUM_ENTRIES-1:0] fill;
   logic [NUM_ENTRIES-1:0] release_en;
   logic [1:0]             fill_count;
   dispatch_t              fill_data [NUM_ENTRIES];
   age_t                   fill_age [NUM_ENTRIES];
   rs_status_e             status [NUM_ENTRIES];
   age_t                   age [NUM_ENTRIES];
   rs_op_t                 op [NUM_ENTRIES];
   value_t                 rega_value [NUM_ENTRIES];
   value_t                 regb_value [NUM_ENTRIES];

   rs_alloc #(.NUM_ENTRIES(NUM_ENTRIES)) i_rs_alloc
   (
      .inst1          (inst1),
      .inst2          (inst2),
      .empty          (empty),
      .fill           (fill),
      .fill_data      (fill_data),
      .fill_age       (fill_age),
      .fill_count     (fill_count),
      .dispatch_ready (dispatch_ready)
   );

   for (genvar g = 0; g < NUM_ENTRIES; g++)
   begin : g_entry
      // an entry issuing this cycle still counts as occupied
      assign empty[g] = (status[g] == RS_EMPTY);

      rs_entry i_rs_entry
      (
         .clock      (clock),
         .reset      (reset),
         .release_en (release_en[g]),
         .fill       (fill[g]),
         .fill_data  (fill_data[g]),
         .fill_age   (fill_age[g]),
         .fill_count (fill_count),
         .cdb1       (cdb1),
         .cdb2       (cdb2),
         .status     (status[g]),
         .age        (age[g]),
         .op         (op[g]),
         .rega_value (rega_value[g]),
         .regb_value (regb_value[g])
      );
   end

   rs_issue_select #(.NUM_ENTRIES(NUM_ENTRIES)) i_rs_issue_select
   (
      .status     (status),
      .age        (age),
      .op         (op),
      .rega_value (rega_value),
      .regb_value (regb_value),
      .release_en (release_en),
      .issue1     (issue1),
      .issue2     (issue2)
   );

endmodule

// ==== rs_issue_select.sv ====
`timescale 1ns/1ps
// chooses the two oldest ready entries and drives the issue ports
// equal ages go to the lower index, so at most one entry wins each port
module rs_issue_select
#(
   parameter int NUM_ENTRIES = 8
)
(
   input  rs_pkg::rs_status_e     status [NUM_ENTRIES],
   input  rs_pkg::age_t           age [NUM_ENTRIES],
   input  rs_pkg::rs_op_t         op [NUM_ENTRIES],
   input  rs_pkg::value_t         rega_value [NUM_ENTRIES],
   input  rs_pkg::value_t         regb_value [NUM_ENTRIES],
   output logic [NUM_ENTRIES-1:0] release_en,
   output rs_pkg::issue_t         issue1,
   output rs_pkg::issue_t         issue2
);

   import rs_pkg::*;

   logic [NUM_ENTRIES-1:0] ready;
   // older[i][j] is set when entry i is older than entry j
   logic [NUM_ENTRIES-1:0] older [NUM_ENTRIES];
   logic [NUM_ENTRIES-1:0] pick1;
   logic [NUM_ENTRIES-1:0] pick2;

   function automatic issue_t entry_issue(rs_op_t o, value_t a, value_t b);
      issue_t r;
      r.valid      = 1'b1;
      r.op         = o;
      r.rega_value = a;
      r.regb_value = b;
      return r;
   endfunction

   ////////////////////////////////////////////////////////////
   // age comparison table
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         ready[i] = (status[i] == RS_READY);
         for (int j = 0; j < NUM_ENTRIES; j++)
            older[i][j] = (age[i] > age[j]) || ((age[i] == age[j]) && (i < j));
      end
   end

   // second pick ignores whatever the first pick took
   always_comb
   begin
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         pick1[i] = ready[i];
         for (int j = 0; j < NUM_ENTRIES; j++)
            if ((j != i) && ready[j] && !older[i][j])
               pick1[i] = 1'b0;
      end
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         pick2[i] = ready[i] && !pick1[i];
         for (int j = 0; j < NUM_ENTRIES; j++)
            if ((j != i) && ready[j] && !pick1[j] && !older[i][j])
               pick2[i] = 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // issue muxes, all zero when nothing is picked
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      issue1 = '0;
      issue2 = '0;
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         if (pick1[i])
            issue1 = entry_issue(op[i], rega_value[i], regb_value[i]);
         if (pick2[i])
            issue2 = entry_issue(op[i], rega_value[i], regb_value[i]);
      end
   end

   assign release_en = pick1 | pick2;

endmodule

// ==== rs_alloc.sv ====
`timescale 1ns/1ps
// picks the first and second empty entries, lowest index first
// dispatch is only accepted while two entries are empty
module rs_alloc
#(
   parameter int NUM_ENTRIES = 8
)
(
   input  rs_pkg::dispatch_t      inst1,
   input  rs_pkg::dispatch_t      inst2,
   input  logic [NUM_ENTRIES-1:0] empty,
   output logic [NUM_ENTRIES-1:0] fill,
   output rs_pkg::dispatch_t      fill_data [NUM_ENTRIES],
   output rs_pkg::age_t           fill_age [NUM_ENTRIES],
   output logic [1:0]             fill_count,
   output logic                   dispatch_ready
);

   import rs_pkg::*;

   logic [NUM_ENTRIES-1:0] first_sel;
   logic [NUM_ENTRIES-1:0] second_sel;
   logic                   found_first;
   logic                   found_second;
   logic                   take1;
   logic                   take2;

   // priority chain from index 0 upward
   always_comb
   begin
      first_sel    = '0;
      second_sel   = '0;
      found_first  = 1'b0;
      found_second = 1'b0;
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         if (empty[i] && !found_first)
         begin
            first_sel[i] = 1'b1;
            found_first  = 1'b1;
         end
         else if (empty[i] && !found_second)
         begin
            second_sel[i] = 1'b1;
            found_second  = 1'b1;
         end
      end
   end

   assign dispatch_ready = found_first && found_second;
   assign take1          = dispatch_ready && inst1.valid;
   assign take2          = dispatch_ready && inst2.valid;
   assign fill_count     = {1'b0, take1} + {1'b0, take2};

   always_comb
   begin
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         fill[i]      = (first_sel[i] && take1) || (second_sel[i] && take2);
         fill_data[i] = '0;
         fill_age[i]  = '0;
         if (first_sel[i] && take1)
         begin
            fill_data[i] = inst1;
            // inst1 is the older one of a pair
            fill_age[i]  = take2 ? age_t'(1) : '0;
         end
         else if (second_sel[i] && take2)
            fill_data[i] = inst2;
      end
   end

endmodule

// ==== rs_entry.sv ====
`timescale 1ns/1ps
// one reservation station entry with operand wakeup
// fill and release_en never come together: only empty entries are filled
// and only ready entries are released
module rs_entry
(
   input  logic               clock,
   input  logic               reset,
   input  logic               release_en,
   input  logic               fill,
   input  rs_pkg::dispatch_t  fill_data,
   input  rs_pkg::age_t       fill_age,
   input  logic [1:0]         fill_count,
   input  rs_pkg::cdb_t       cdb1,
   input  rs_pkg::cdb_t       cdb2,
   output rs_pkg::rs_status_e status,
   output rs_pkg::age_t       age,
   output rs_pkg::rs_op_t     op,
   output rs_pkg::value_t     rega_value,
   output rs_pkg::value_t     regb_value
);

   import rs_pkg::*;

   tag_t                   tag_a;
   tag_t                   tag_b;
   tag_t                   src_tag_a;
   tag_t                   src_tag_b;
   value_t                 src_value_a;
   value_t                 src_value_b;
   tag_t                   next_tag_a;
   tag_t                   next_tag_b;
   value_t                 next_value_a;
   value_t                 next_value_b;
   rs_status_e             next_status;
   age_t                   next_age;
   logic [$bits(age_t):0]  age_sum;

   function automatic logic cdb_hit(tag_t t, cdb_t c);
      return (t != TAG_NULL) && (t == c.tag);
   endfunction

   // cdb1 wins when both buses carry the same tag
   function automatic value_t woken_value(tag_t t, value_t v, cdb_t c1, cdb_t c2);
      if (cdb_hit(t, c1))
         return c1.value;
      else if (cdb_hit(t, c2))
         return c2.value;
      return v;
   endfunction

   function automatic rs_status_e status_from_tags(tag_t ta, tag_t tb);
      case ({ta != TAG_NULL, tb != TAG_NULL})
         2'b00:   return RS_READY;
         2'b01:   return RS_WAITING_B;
         2'b10:   return RS_WAITING_A;
         default: return RS_WAITING_BOTH;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // wakeup and next state
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      // an instruction being written is woken exactly like a stored one
      src_tag_a   = fill ? fill_data.rega_tag   : tag_a;
      src_tag_b   = fill ? fill_data.regb_tag   : tag_b;
      src_value_a = fill ? fill_data.rega_value : rega_value;
      src_value_b = fill ? fill_data.regb_value : regb_value;

      next_tag_a   = (cdb_hit(src_tag_a, cdb1) || cdb_hit(src_tag_a, cdb2)) ? TAG_NULL : src_tag_a;
      next_tag_b   = (cdb_hit(src_tag_b, cdb1) || cdb_hit(src_tag_b, cdb2)) ? TAG_NULL : src_tag_b;
      next_value_a = woken_value(src_tag_a, src_value_a, cdb1, cdb2);
      next_value_b = woken_value(src_tag_b, src_value_b, cdb1, cdb2);

      if (release_en)
         next_status = RS_EMPTY;
      else if (fill || (status != RS_EMPTY))
         next_status = status_from_tags(next_tag_a, next_tag_b);
      else
         next_status = RS_EMPTY;

      // occupied entries grow older by the number of newcomers
      age_sum = {1'b0, age} + ($bits(age_t) + 1)'(fill_count);
      if (release_en)
         next_age = '0;
      else if (fill)
         next_age = fill_age;
      else if (status != RS_EMPTY)
         next_age = age_sum[$bits(age_t)] ? '1 : age_t'(age_sum);
      else
         next_age = age;
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         status <= RS_EMPTY;
         age    <= '0;
         tag_a  <= TAG_NULL;
         tag_b  <= TAG_NULL;
      end
      else
      begin
         status <= next_status;
         age    <= next_age;
         tag_a  <= next_tag_a;
         tag_b  <= next_tag_b;
      end
   end

   // operand values and payload
   always_ff @(posedge clock)
   begin
      rega_value <= next_value_a;
      regb_value <= next_value_b;
      if (fill)
         op <= fill_data.op;
   end

endmodule

// ==== rs_pkg.sv ====
// shared types for the reservation station
// the all-ones tag is reserved: operand present, or no broadcast on a cdb
package rs_pkg;

   ////////////////////////////////////////////////////////////
   // vector types
   ////////////////////////////////////////////////////////////

   // rename tag of the producing instruction
   typedef logic [7:0]  tag_t;
   typedef logic [63:0] value_t;
   // relative age, larger is older, saturates
   typedef logic [7:0]  age_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [4:0]  alu_func_t;
   typedef logic [1:0]  opsel_t;

   localparam tag_t TAG_NULL = '1;

   // entry state
   typedef enum logic [2:0]
   {
      RS_EMPTY        = 3'b000,
      RS_WAITING_A    = 3'b001,
      RS_WAITING_B    = 3'b010,
      RS_WAITING_BOTH = 3'b011,
      RS_READY        = 3'b100
   } rs_status_e;

   ////////////////////////////////////////////////////////////
   // bundles
   ////////////////////////////////////////////////////////////

   // carried through the station untouched
   typedef struct packed
   {
      opsel_t    opa_select;
      opsel_t    opb_select;
      alu_func_t alu_func;
      logic      rd_mem;
      logic      wr_mem;
      logic      cond_branch;
      logic      uncond_branch;
      reg_idx_t  dest_reg;
      tag_t      dest_tag;
   } rs_op_t;

   // one decoded instruction from decode
   typedef struct packed
   {
      logic   valid;
      rs_op_t op;
      value_t rega_value;
      value_t regb_value;
      tag_t   rega_tag;
      tag_t   regb_tag;
   } dispatch_t;

   typedef struct packed
   {
      tag_t   tag;
      value_t value;
   } cdb_t;

   // one instruction towards execute
   typedef struct packed
   {
      logic   valid;
      rs_op_t op;
      value_t rega_value;
      value_t regb_value;
   } issue_t;

endpackage
